//--- sim.f
+incdir+include
verilog/i2s_pkg.sv
verilog/i2s_sample_fifo.sv
verilog/i2s_control_fsm.sv
verilog/i2s_clock_gen.sv
verilog/i2s_serializer.sv
verilog/i2s_unit.sv
testbench/i2s_unit_assert.sv
testbench/i2s_unit_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module i2s_unit_tb -f sim.f \
   && ./obj_dir/Vi2s_unit_tb | tee /dev/stderr | grep -q -F '*** PASSED ***' \
   && echo "run.sh: simulation ok" \
   || { echo "run.sh: simulation did not pass"; exit 1; }

//--- testbench/i2s_unit_tb.sv
`timescale 1ns/1ps

`include "i2s_config.svh"

module i2s_unit_tb;

   // ----------------------------------------------------------------------
   // run sizing
   // ----------------------------------------------------------------------
   localparam int frames_per_run = 5;
   localparam int num_runs       = 4;
   localparam int quiet_cycles   = 64;
   // fill, stop detection, quiet window and config per run
   localparam int fill_cycles    = `I2S_FIFO_DEPTH * 16 + 4 * quiet_cycles;
   localparam longint frame_ns   = `I2S_FRAME_BITS * `I2S_DIV_48K * 40;
   localparam longint watchdog_ns = 2 * num_runs * (frames_per_run + 2) * frame_ns
                                    + (num_runs + 1) * fill_cycles * 40;

   logic             clk = 1'b0;
   logic             rst_n;
   logic             play_in;
   logic             tick_in = 1'b0;
   i2s_pkg::sample_t audio_in_0 = '0;
   i2s_pkg::sample_t audio_in_1 = '0;
   logic             cfg_in;
   i2s_pkg::rate_t   cfg_reg_in;
   logic             req_out;
   logic             sck_out;
   logic             ws_out;
   logic             sdo_out;

   integer            seed = 32'h89206668;
   string             test_name = "reset";
   int                run_id = 0;
   i2s_pkg::rate_t    model_rate = i2s_pkg::rate_48k;
   i2s_pkg::sck_div_t cur_div = i2s_pkg::sck_div_t'(`I2S_DIV_48K);
   // frames handed to the DUT, oldest first
   i2s_pkg::frame_t   expected_q[$];

   // decoder state
   int                         seen_run = 0;
   int                         frames_done = 0;
   int                         bits_in_frame = 0;
   int                         gap_cycles = 0;
   logic                       gap_valid = 1'b0;
   logic                       collecting = 1'b0;
   logic                       sck_last = 1'b0;
   logic                       ws_last = 1'b1;
   logic [`I2S_FRAME_BITS-1:0] frame_bits = '0;

   i2s_unit u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .play_in    (play_in),
      .tick_in    (tick_in),
      .audio_in_0 (audio_in_0),
      .audio_in_1 (audio_in_1),
      .cfg_in     (cfg_in),
      .cfg_reg_in (cfg_reg_in),
      .req_out    (req_out),
      .sck_out    (sck_out),
      .ws_out     (ws_out),
      .sdo_out    (sdo_out)
   );

   bind i2s_unit i2s_unit_assert u_assert (
      .clk     (clk),
      .rst_n   (rst_n),
      .state   (state),
      .req_out (req_out),
      .sck_out (sck_out),
      .ws_out  (ws_out)
   );

   // 40 ns system clock
   always #20 clk = ~clk;

   // ----------------------------------------------------------------------
   // reference model
   // ----------------------------------------------------------------------
   // next frame owed by the DUT, zeros on underflow
   function automatic i2s_pkg::frame_t expected_frame();
      if (expected_q.size() == 0)
         return '0;
      return expected_q.pop_front();
   endfunction

   function automatic i2s_pkg::sck_div_t div_for_rate(input i2s_pkg::rate_t rate);
      case (rate)
         i2s_pkg::rate_96k:  return i2s_pkg::sck_div_t'(`I2S_DIV_96K);
         i2s_pkg::rate_192k: return i2s_pkg::sck_div_t'(`I2S_DIV_192K);
         default:            return i2s_pkg::sck_div_t'(`I2S_DIV_48K);
      endcase
   endfunction

   function automatic logic rate_is_valid(input i2s_pkg::rate_t rate);
      return (rate == i2s_pkg::rate_48k) || (rate == i2s_pkg::rate_96k) ||
             (rate == i2s_pkg::rate_192k);
   endfunction

   // ws high from the left LSB up to the right LSB
   function automatic logic expected_ws(input int pos);
      return (pos >= `I2S_SAMPLE_W - 1) && (pos < `I2S_FRAME_BITS - 1);
   endfunction

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   task automatic stop_run(input string line);
      $display("%s", line);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_frame(input string name, input i2s_pkg::frame_t exp,
                              input i2s_pkg::frame_t act);
      if (act !== exp)
         stop_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_div(input string name, input i2s_pkg::sck_div_t exp,
                            input i2s_pkg::sck_div_t act);
      if (act !== exp)
         stop_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
         stop_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
   endtask

   // ----------------------------------------------------------------------
   // sample source
   // ----------------------------------------------------------------------
   // one tick per request, 1 to 6 cycles late
   task automatic answer_request();
      int              delay;
      i2s_pkg::frame_t frame;
      delay       = 1 + ($unsigned($random(seed)) % 6);
      frame.left  = i2s_pkg::sample_t'($random(seed));
      frame.right = i2s_pkg::sample_t'($random(seed));
      repeat (delay - 1) @(posedge clk);
      audio_in_0 <= frame.left;
      audio_in_1 <= frame.right;
      tick_in    <= 1'b1;
      expected_q.push_back(frame);
      @(posedge clk);
      tick_in <= 1'b0;
   endtask

   always @(posedge clk)
   begin
      if (rst_n && req_out)
         answer_request();
   end

   // ----------------------------------------------------------------------
   // frame decoder and compare
   // ----------------------------------------------------------------------
   always @(posedge clk)
   begin
      gap_cycles++;
      if (seen_run != run_id)
      begin
         // new play run, drop what the last one left queued
         seen_run      = run_id;
         collecting    = 1'b0;
         bits_in_frame = 0;
         frames_done   = 0;
         gap_valid     = 1'b0;
         ws_last       = 1'b1;
         expected_q.delete();
      end
      else if (sck_out && !sck_last)
      begin
         if (gap_valid)
            check_div({test_name, " sck period"}, cur_div,
                      i2s_pkg::sck_div_t'(gap_cycles));
         gap_valid  = 1'b1;
         gap_cycles = 0;
         if (collecting)
         begin
            check_bit($sformatf("%s ws at bit %0d", test_name, bits_in_frame),
                      expected_ws(bits_in_frame), ws_out);
            frame_bits = {frame_bits[`I2S_FRAME_BITS-2:0], sdo_out};
            bits_in_frame++;
            if (bits_in_frame == `I2S_FRAME_BITS)
            begin
               check_frame(test_name, expected_frame(), i2s_pkg::frame_t'(frame_bits));
               frames_done++;
               collecting = 1'b0;
            end
         end
         // ws fall, left MSB comes on the next rise
         if (ws_last && !ws_out)
         begin
            collecting    = 1'b1;
            bits_in_frame = 0;
         end
         ws_last = ws_out;
      end
      sck_last = sck_out;
   end

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   task automatic expect_quiet(input string name, input int cycles);
      repeat (cycles)
      begin
         @(posedge clk);
         check_bit({name, " req_out"}, 1'b0, req_out);
         check_bit({name, " sck_out"}, 1'b0, sck_out);
         check_bit({name, " ws_out"}, 1'b0, ws_out);
         check_bit({name, " sdo_out"}, 1'b0, sdo_out);
      end
   endtask

   // one cfg pulse, the model follows only valid codes
   task automatic configure(input i2s_pkg::rate_t code);
      @(posedge clk);
      cfg_in     <= 1'b1;
      cfg_reg_in <= code;
      @(posedge clk);
      cfg_in <= 1'b0;
      if (rate_is_valid(code))
         model_rate = code;
      cur_div = div_for_rate(model_rate);
   endtask

   task automatic play_session(input string name, input int nframes, input logic cfg_in_play);
      int   req_count;
      int   low_run;
      int   frames_at_drop;
      logic sck_seen;
      test_name = name;
      req_count = 0;
      sck_seen  = 1'b0;
      @(posedge clk);
      play_in <= 1'b1;
      run_id  <= run_id + 1;
      // fill requests up to the first bit clock
      while (!sck_seen)
      begin
         @(posedge clk);
         if (sck_out)
            sck_seen = 1'b1;
         else if (req_out)
            req_count++;
      end
      check_count({name, " fill requests"}, `I2S_FIFO_DEPTH, req_count);
      if (cfg_in_play)
      begin
         cfg_in     <= 1'b1;
         cfg_reg_in <= i2s_pkg::rate_48k;
         @(posedge clk);
         cfg_in <= 1'b0;
      end
      while (frames_done < nframes)
         @(posedge clk);
      // drop play in the middle of a frame
      while (bits_in_frame < 8)
         @(posedge clk);
      frames_at_drop = frames_done;
      play_in <= 1'b0;
      low_run = 0;
      while (low_run < 2 * `I2S_DIV_48K)
      begin
         @(posedge clk);
         if (sck_out)
            low_run = 0;
         else
            low_run++;
      end
      check_count({name, " frames at stop"}, frames_at_drop + 1, frames_done);
      check_count({name, " bits left at stop"}, 0, bits_in_frame);
      expect_quiet({name, " stopped"}, quiet_cycles);
   endtask

   initial
   begin
      rst_n      = 1'b0;
      play_in    = 1'b0;
      cfg_in     = 1'b0;
      cfg_reg_in = i2s_pkg::rate_48k;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      test_name = "idle";
      expect_quiet("idle", quiet_cycles);
      configure(i2s_pkg::rate_48k);
      play_session("rate_48k", frames_per_run, 1'b0);
      configure(i2s_pkg::rate_96k);
      play_session("rate_96k", frames_per_run, 1'b0);
      // cfg pulse while playing must not touch the divider
      configure(i2s_pkg::rate_192k);
      play_session("rate_192k_cfg_in_play", frames_per_run, 1'b1);
      // code 3 keeps 192 kHz
      configure(i2s_pkg::rate_t'(2'd3));
      play_session("invalid_code", frames_per_run, 1'b0);
      $display("*** PASSED ***");
      $finish;
   end

   // watchdog
   initial
   begin
      #(watchdog_ns);
      stop_run("timed out waiting for the DUT to finish the playback runs");
   end

endmodule

//--- testbench/i2s_unit_assert.sv
`timescale 1ns/1ps

module i2s_unit_assert (
   input logic                 clk,
   input logic                 rst_n,
   input i2s_pkg::ctrl_state_t state,
   input logic                 req_out,
   input logic                 sck_out,
   input logic                 ws_out
);

   // ----------------------------------------------------------------------
   // request handshake
   // ----------------------------------------------------------------------
   // a request is a single cycle pulse
   req_one_cycle : assert property (
      @(posedge clk) disable iff (!rst_n)
      req_out |=> !req_out
   ) else $error("req_out stayed high for more than one cycle");

   // ----------------------------------------------------------------------
   // bit clock and word select
   // ----------------------------------------------------------------------
   // ws only moves together with a falling sck
   ws_on_sck_fall : assert property (
      @(posedge clk) disable iff (!rst_n)
      (ws_out != $past(ws_out)) |-> ($past(sck_out) && !sck_out)
   ) else $error("ws_out changed away from a falling sck_out edge");

   // no bit clock while stopped
   sck_low_in_stop : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == i2s_pkg::st_stop) |-> !sck_out
   ) else $error("sck_out high while the unit is stopped");

endmodule

//--- verilog/i2s_unit.sv
`timescale 1ns/1ps

module i2s_unit (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              play_in,
   input  logic              tick_in,
   input  i2s_pkg::sample_t  audio_in_0,
   input  i2s_pkg::sample_t  audio_in_1,
   input  logic              cfg_in,
   input  i2s_pkg::rate_t    cfg_reg_in,
   output logic              req_out,
   output logic              sck_out,
   output logic              ws_out,
   output logic              sdo_out
);

   i2s_pkg::ctrl_state_t  state;
   i2s_pkg::sck_div_t     sck_div;
   i2s_pkg::bit_strobes_t strobes;
   i2s_pkg::frame_t       wr_frame;
   i2s_pkg::frame_t       rd_frame;
   logic                  full;
   logic                  empty;
   logic                  clear;

   // left channel in the upper half
   assign wr_frame.left  = audio_in_0;
   assign wr_frame.right = audio_in_1;

   // stopped unit drops queued frames and output data
   assign clear = (state == i2s_pkg::st_stop);

   // ----------------------------------------------------------------------
   // input side
   // ----------------------------------------------------------------------
   i2s_sample_fifo u_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (clear),
      .wr_en    (tick_in),
      .wr_frame (wr_frame),
      .rd_en    (strobes.load),
      .rd_frame (rd_frame),
      .full     (full),
      .empty    (empty)
   );

   // ----------------------------------------------------------------------
   // control and timing
   // ----------------------------------------------------------------------
   i2s_control_fsm u_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .play_in    (play_in),
      .tick_in    (tick_in),
      .cfg_in     (cfg_in),
      .cfg_reg_in (cfg_reg_in),
      .full       (full),
      .strobes    (strobes),
      .state      (state),
      .sck_div    (sck_div),
      .req_out    (req_out)
   );

   i2s_clock_gen u_clk_gen (
      .clk     (clk),
      .rst_n   (rst_n),
      .state   (state),
      .sck_div (sck_div),
      .sck_out (sck_out),
      .ws_out  (ws_out),
      .strobes (strobes)
   );

   // output side
   i2s_serializer u_ser (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (clear),
      .strobes  (strobes),
      .empty    (empty),
      .rd_frame (rd_frame),
      .sdo_out  (sdo_out)
   );

endmodule

//--- verilog/i2s_serializer.sv
`timescale 1ns/1ps

`include "i2s_config.svh"

module i2s_serializer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  clear,
   input  i2s_pkg::bit_strobes_t strobes,
   input  logic                  empty,
   input  i2s_pkg::frame_t       rd_frame,
   output logic                  sdo_out
);

   // output shift register, MSB goes out first
   logic [`I2S_FRAME_BITS-1:0] srg_r;

   // ----------------------------------------------------------------------
   // load, shift, clear
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         srg_r <= '0;
      else if (clear)
         srg_r <= '0;
      else if (strobes.load)
      begin
         // nothing queued, the frame goes out as zeros
         if (!empty)
            srg_r <= rd_frame;
         else
            srg_r <= {srg_r[`I2S_FRAME_BITS-2:0], 1'b0};
      end
      else if (strobes.shift)
         // zero fill behind the data
         srg_r <= {srg_r[`I2S_FRAME_BITS-2:0], 1'b0};
   end

   assign sdo_out = srg_r[`I2S_FRAME_BITS-1];

endmodule

//--- verilog/i2s_clock_gen.sv
`timescale 1ns/1ps

`include "i2s_config.svh"

module i2s_clock_gen (
   input  logic                  clk,
   input  logic                  rst_n,
   input  i2s_pkg::ctrl_state_t  state,
   input  i2s_pkg::sck_div_t     sck_div,
   output logic                  sck_out,
   output logic                  ws_out,
   output i2s_pkg::bit_strobes_t strobes
);

   localparam int fbit_w = $clog2(`I2S_FRAME_BITS);
   // last bit of the left and of the right channel
   localparam logic [fbit_w-1:0] left_last  = fbit_w'(`I2S_SAMPLE_W - 1);
   localparam logic [fbit_w-1:0] right_last = fbit_w'(`I2S_FRAME_BITS - 1);

   // system clocks within one bit period
   i2s_pkg::sck_div_t sck_ctr_r;
   // bit position within the frame
   logic [fbit_w-1:0] fbit_r;
   logic              sck_r;
   logic              ws_r;

   logic              playing;
   i2s_pkg::sck_div_t half_div;
   i2s_pkg::sck_div_t last_cnt;
   logic              at_wrap;
   logic              at_mid;

   assign playing  = (state == i2s_pkg::st_play);
   assign half_div = sck_div >> 1;
   assign last_cnt = sck_div - 1'b1;
   assign at_wrap  = playing && (sck_ctr_r == last_cnt);
   // falling sck edge, data and ws move here
   assign at_mid   = playing && (sck_ctr_r == half_div);

   // ----------------------------------------------------------------------
   // counters and waveforms
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sck_ctr_r <= '0;
         fbit_r    <= '0;
         sck_r     <= 1'b0;
         ws_r      <= 1'b0;
      end
      else if (!playing)
      begin
         sck_ctr_r <= '0;
         fbit_r    <= '0;
         sck_r     <= 1'b0;
         ws_r      <= 1'b0;
      end
      else
      begin
         sck_ctr_r <= at_wrap ? '0 : sck_ctr_r + 1'b1;
         if (at_wrap)
            fbit_r <= (fbit_r == right_last) ? '0 : fbit_r + 1'b1;
         // high during the first half of the bit
         sck_r <= (sck_ctr_r < half_div);
         // one bit ahead of each channel MSB
         if (at_mid && ((fbit_r == left_last) || (fbit_r == right_last)))
            ws_r <= ~ws_r;
      end
   end

   // frame start loads, every other bit shifts
   assign strobes.load  = at_mid && (fbit_r == '0);
   assign strobes.shift = at_mid && (fbit_r != '0);

   assign sck_out = sck_r;
   assign ws_out  = ws_r;

endmodule

//--- verilog/i2s_control_fsm.sv
`timescale 1ns/1ps

`include "i2s_config.svh"

module i2s_control_fsm (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  play_in,
   input  logic                  tick_in,
   input  logic                  cfg_in,
   input  i2s_pkg::rate_t        cfg_reg_in,
   input  logic                  full,
   input  i2s_pkg::bit_strobes_t strobes,
   output i2s_pkg::ctrl_state_t  state,
   output i2s_pkg::sck_div_t     sck_div,
   output logic                  req_out
);

   i2s_pkg::ctrl_state_t state_r;
   i2s_pkg::ctrl_state_t state_nxt;
   i2s_pkg::rate_t       rate_r;

   // ----------------------------------------------------------------------
   // playback sequencing
   // ----------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state_r;
      case (state_r)
         i2s_pkg::st_stop:
            if (play_in)
               state_nxt = i2s_pkg::st_fill;
         i2s_pkg::st_fill:
            // keep requesting until the FIFO is full
            if (!play_in)
               state_nxt = i2s_pkg::st_stop;
            else if (full)
               state_nxt = i2s_pkg::st_play;
            else
               state_nxt = i2s_pkg::st_req;
         i2s_pkg::st_req:
            if (!play_in)
               state_nxt = i2s_pkg::st_stop;
            else
               state_nxt = i2s_pkg::st_load;
         i2s_pkg::st_load:
            // wait for the source to answer
            if (!play_in)
               state_nxt = i2s_pkg::st_stop;
            else if (tick_in)
               state_nxt = i2s_pkg::st_fill;
         i2s_pkg::st_play:
            // only leave at a frame boundary
            if (strobes.load && !play_in)
               state_nxt = i2s_pkg::st_stop;
         default:
            state_nxt = i2s_pkg::st_stop;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_r <= i2s_pkg::st_stop;
      else
         state_r <= state_nxt;
   end

   // ----------------------------------------------------------------------
   // rate register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rate_r <= i2s_pkg::rate_48k;
      else if (cfg_in && !play_in && (state_r == i2s_pkg::st_stop))
      begin
         case (cfg_reg_in)
            i2s_pkg::rate_48k,
            i2s_pkg::rate_96k,
            i2s_pkg::rate_192k:
               rate_r <= cfg_reg_in;
            // invalid code, keep the old rate
            default:
               rate_r <= rate_r;
         endcase
      end
   end

   // rate to bit clock divider
   always_comb
   begin
      case (rate_r)
         i2s_pkg::rate_96k:  sck_div = i2s_pkg::sck_div_t'(`I2S_DIV_96K);
         i2s_pkg::rate_192k: sck_div = i2s_pkg::sck_div_t'(`I2S_DIV_192K);
         default:            sck_div = i2s_pkg::sck_div_t'(`I2S_DIV_48K);
      endcase
   end

   // one request per fill step, one per frame while playing
   assign req_out = (state_r == i2s_pkg::st_req) ||
                    ((state_r == i2s_pkg::st_play) && play_in && strobes.load);

   assign state = state_r;

endmodule

//--- verilog/i2s_sample_fifo.sv
`timescale 1ns/1ps

`include "i2s_config.svh"

module i2s_sample_fifo (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            clear,
   input  logic            wr_en,
   input  i2s_pkg::frame_t wr_frame,
   input  logic            rd_en,
   output i2s_pkg::frame_t rd_frame,
   output logic            full,
   output logic            empty
);

   localparam int ptr_w = $clog2(`I2S_FIFO_DEPTH);
   localparam logic [ptr_w-1:0] last_idx = ptr_w'(`I2S_FIFO_DEPTH - 1);

   // frame storage
   i2s_pkg::frame_t mem [`I2S_FIFO_DEPTH];

   // head is the write side, tail the read side
   logic [ptr_w-1:0] head_r;
   logic [ptr_w-1:0] tail_r;
   // head is one lap ahead of tail
   logic             looped_r;

   logic do_wr;
   logic do_rd;
   logic head_wrap;
   logic tail_wrap;

   // ----------------------------------------------------------------------
   // status
   // ----------------------------------------------------------------------
   assign full  = (head_r == tail_r) && looped_r;
   assign empty = (head_r == tail_r) && !looped_r;

   // writes when full and reads when empty are lost
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign head_wrap = do_wr && (head_r == last_idx);
   assign tail_wrap = do_rd && (tail_r == last_idx);

   // head of the queue, valid only when not empty
   assign rd_frame = mem[tail_r];

   // ----------------------------------------------------------------------
   // pointers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_r   <= '0;
         tail_r   <= '0;
         looped_r <= 1'b0;
      end
      else if (clear)
      begin
         head_r   <= '0;
         tail_r   <= '0;
         looped_r <= 1'b0;
      end
      else
      begin
         if (do_wr)
            head_r <= head_wrap ? '0 : head_r + 1'b1;
         if (do_rd)
            tail_r <= tail_wrap ? '0 : tail_r + 1'b1;
         // both wrapping in one cycle leaves the lap count alone
         looped_r <= looped_r ^ head_wrap ^ tail_wrap;
      end
   end

   // storage write
   always_ff @(posedge clk)
   begin
      if (do_wr && !clear)
         mem[head_r] <= wr_frame;
   end

endmodule

//--- verilog/i2s_pkg.sv
`include "i2s_config.svh"

package i2s_pkg;

   // ----------------------------------------------------------------------
   // audio payload
   // ----------------------------------------------------------------------
   // one channel sample
   typedef logic [`I2S_SAMPLE_W-1:0] sample_t;

   // left sits in the upper half, so it goes out first
   typedef struct packed {
      sample_t left;
      sample_t right;
   } frame_t;

   // ----------------------------------------------------------------------
   // configuration and control
   // ----------------------------------------------------------------------
   // code 3 is not a rate
   typedef enum logic [1:0] {
      rate_48k  = 2'd0,
      rate_96k  = 2'd1,
      rate_192k = 2'd2
   } rate_t;

   // system clocks per bit clock period
   typedef logic [`I2S_SCK_DIV_W-1:0] sck_div_t;

   typedef enum logic [2:0] {
      st_stop,
      st_fill,
      st_req,
      st_load,
      st_play
   } ctrl_state_t;

   // load marks a frame start and also the stop boundary
   typedef struct packed {
      logic load;
      logic shift;
   } bit_strobes_t;

endpackage

//--- include/i2s_config.svh
`ifndef I2S_CONFIG_SVH
`define I2S_CONFIG_SVH

// ----------------------------------------------------------------------
// sample and frame sizes
// ----------------------------------------------------------------------
// bits per channel
`define I2S_SAMPLE_W 24
// left plus right
`define I2S_FRAME_BITS 48
// stereo frames held in the FIFO
`define I2S_FIFO_DEPTH 4

// ----------------------------------------------------------------------
// system clocks per sck period, one per rate
// ----------------------------------------------------------------------
`define I2S_DIV_48K 8
`define I2S_DIV_96K 4
`define I2S_DIV_192K 2
// wide enough for the largest divider
`define I2S_SCK_DIV_W 4

`endif
